//--- tb.f
verilog/vertex_shader_pkg.sv
verilog/inv_sqrt.sv
verilog/cross_product.sv
verilog/neg_dot_product.sv
verilog/camera_basis.sv
verilog/vertex_transform.sv
verilog/vertex_shader.sv
verif/vertex_shader_properties.sv
verif/tb_vertex_shader.sv

//--- verif/tb_vertex_shader.sv
`default_nettype none

module tb_vertex_shader import vertex_shader_pkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int CAMERAS = 5;
	localparam int VERTICES = 20;
	// five cameras, under 70 setup and about 30 vertex cycles each, plus margin
	localparam int TIMEOUT_CYCLES = 1000;
	// ranges in 4Q20 steps, 3.5, 2.0 and 4.0
	localparam int CAM_LIM = 3670016;
	localparam int OFFSET_LIM = 2097152;
	localparam int COORD_LIM = 4194304;

	logic clk;
	logic srst_n;
	logic enable;
	camera_t camera;
	logic vertex_valid;
	vec3_t vertex_in;
	view_mat_t view;
	logic view_ready;
	logic view_valid;
	logic out_valid;
	vec3_t vertex_out;

	logic [31:0] seed = 32'h2ca5d39c;
	int cycles = 0;

	vertex_shader #(
		.INV_SQRT_STAGES(INV_SQRT_STAGES)
	) dut0 (
		.clk(clk),
		.srst_n(srst_n),
		.enable(enable),
		.camera(camera),
		.vertex_valid(vertex_valid),
		.vertex_in(vertex_in),
		.view(view),
		.view_ready(view_ready),
		.view_valid(view_valid),
		.out_valid(out_valid),
		.vertex_out(vertex_out)
	);

	bind vertex_shader vertex_shader_properties props0 (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// uniform in [-lim, lim)
	function automatic fix_t rand_fix(input int lim);
		int unsigned r;
		seed = xorshift(seed);
		r = seed % (2 * lim);
		return fix_t'(int'(r) - lim);
	endfunction

	function automatic logic random_bit();
		seed = xorshift(seed);
		return seed[7];
	endfunction

	function automatic real fix_to_real(input fix_t f);
		return real'(f) / 1048576.0;
	endfunction

	// within 2.0 of the eye, clipped to 4.0
	function automatic fix_t near_coord(input fix_t e);
		int t;
		t = int'(e) + int'(rand_fix(OFFSET_LIM));
		if (t > COORD_LIM)
			t = COORD_LIM;
		if (t < -COORD_LIM)
			t = -COORD_LIM;
		return fix_t'(t);
	endfunction

	function automatic vec3_t make_vertex(input vec3_t eye);
		vec3_t v;
		v.x = near_coord(eye.x);
		v.y = near_coord(eye.y);
		v.z = near_coord(eye.z);
		return v;
	endfunction

	// eye and center at least 0.55 apart, up at least 30 degrees off the view line
	task automatic make_camera(output camera_t c);
		real dx;
		real dy;
		real dz;
		real d2;
		real u2;
		real ud;
		do begin
			c.eye.x = rand_fix(CAM_LIM);
			c.eye.y = rand_fix(CAM_LIM);
			c.eye.z = rand_fix(CAM_LIM);
			c.center.x = rand_fix(CAM_LIM);
			c.center.y = rand_fix(CAM_LIM);
			c.center.z = rand_fix(CAM_LIM);
			c.up.x = rand_fix(CAM_LIM);
			c.up.y = rand_fix(CAM_LIM);
			c.up.z = rand_fix(CAM_LIM);
			dx = fix_to_real(c.eye.x) - fix_to_real(c.center.x);
			dy = fix_to_real(c.eye.y) - fix_to_real(c.center.y);
			dz = fix_to_real(c.eye.z) - fix_to_real(c.center.z);
			d2 = dx * dx + dy * dy + dz * dz;
			u2 = fix_to_real(c.up.x) ** 2 + fix_to_real(c.up.y) ** 2
				+ fix_to_real(c.up.z) ** 2;
			ud = fix_to_real(c.up.x) * dx + fix_to_real(c.up.y) * dy
				+ fix_to_real(c.up.z) * dz;
		end while (d2 < 0.3 || u2 < 1.44 || ud * ud > 0.75 * d2 * u2);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// assertion failures and the cycle limit
	always @(negedge clk) begin
		cycles++;
		if (dut0.props0.fail_count != 0) begin
			$display("Done: errors found");
			$fatal(1, "an assertion in the property checker failed");
		end else if (cycles >= TIMEOUT_CYCLES) begin
			$display("Done: errors found");
			$fatal(1, "the run timed out after %0d cycles", cycles);
		end
	end

	// ************************************************************
	// stimulus
	// ************************************************************

	initial begin
		camera_t cam;
		int sent;
		int waited;
		srst_n = 1'b0;
		enable = 1'b0;
		camera = '0;
		vertex_valid = 1'b0;
		vertex_in = '0;
		repeat (RESET_CYCLES) next_cycle();
		srst_n = 1'b1;
		for (int n = 0; n < CAMERAS; n++) begin
			make_camera(cam);
			camera = cam;
			enable = 1'b1;
			next_cycle();
			waited = 0;
			// vertices and a second enable during setup are both dropped
			while (!view_ready) begin
				enable = (waited == 3);
				vertex_valid = random_bit();
				vertex_in = make_vertex(cam.eye);
				waited++;
				next_cycle();
			end
			enable = 1'b0;
			// back to back first, then with gaps
			sent = 0;
			while (sent < VERTICES) begin
				vertex_valid = (sent < VERTICES / 2) || random_bit();
				vertex_in = make_vertex(cam.eye);
				if (vertex_valid)
					sent++;
				next_cycle();
			end
			vertex_valid = 1'b0;
			repeat (3) next_cycle();
		end
		if (dut0.props0.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "the property checker reported failures");
		end
	end

endmodule

`default_nettype wire

//--- verif/vertex_shader_properties.sv
`default_nettype none

module vertex_shader_properties import vertex_shader_pkg::*; (
	input wire clk,
	input wire srst_n,
	input wire camera_t camera,
	input wire vertex_valid,
	input wire vec3_t vertex_in,
	input wire view_mat_t view,
	input wire view_ready,
	input wire view_valid,
	input wire out_valid,
	input wire vec3_t vertex_out
);

	localparam real AXIS_TOL = 1.0 / 4096.0;
	localparam real TRANS_TOL = 1.0 / 1024.0;
	localparam real VERTEX_TOL = 1.0 / 256.0;

	int fail_count = 0;
	logic seen_ready;

	// 2Q24 and 4Q20 words as reals
	function automatic real ur(input unit_t u);
		return real'(u) / 16777216.0;
	endfunction

	function automatic real fr(input fix_t f);
		return real'(f) / 1048576.0;
	endfunction

	function automatic real dot_uu(input uvec3_t a, input uvec3_t b);
		return ur(a.x) * ur(b.x) + ur(a.y) * ur(b.y) + ur(a.z) * ur(b.z);
	endfunction

	function automatic real dot_uf(input uvec3_t a, input vec3_t b);
		return ur(a.x) * fr(b.x) + ur(a.y) * fr(b.y) + ur(a.z) * fr(b.z);
	endfunction

	function automatic bit near(input real a, input real b, input real tol);
		return (a - b <= tol) && (b - a <= tol);
	endfunction

	function automatic bit orthonormal(input view_mat_t m);
		return near($sqrt(dot_uu(m.x_axis, m.x_axis)), 1.0, AXIS_TOL)
			&& near($sqrt(dot_uu(m.y_axis, m.y_axis)), 1.0, AXIS_TOL)
			&& near($sqrt(dot_uu(m.z_axis, m.z_axis)), 1.0, AXIS_TOL)
			&& near(dot_uu(m.x_axis, m.y_axis), 0.0, AXIS_TOL)
			&& near(dot_uu(m.x_axis, m.z_axis), 0.0, AXIS_TOL)
			&& near(dot_uu(m.y_axis, m.z_axis), 0.0, AXIS_TOL);
	endfunction

	// z along eye - center, x square to up
	function automatic bit follows_camera(input view_mat_t m, input camera_t c);
		real dx;
		real dy;
		real dz;
		real len;
		real up_len;
		dx = fr(c.eye.x) - fr(c.center.x);
		dy = fr(c.eye.y) - fr(c.center.y);
		dz = fr(c.eye.z) - fr(c.center.z);
		len = $sqrt(dx * dx + dy * dy + dz * dz);
		up_len = $sqrt(fr(c.up.x) ** 2 + fr(c.up.y) ** 2 + fr(c.up.z) ** 2);
		return near(ur(m.z_axis.x), dx / len, AXIS_TOL)
			&& near(ur(m.z_axis.y), dy / len, AXIS_TOL)
			&& near(ur(m.z_axis.z), dz / len, AXIS_TOL)
			&& near(dot_uf(m.x_axis, c.up) / up_len, 0.0, AXIS_TOL);
	endfunction

	function automatic bit trans_ok(input view_mat_t m, input vec3_t eye);
		return near(fr(m.trans.x), -dot_uf(m.x_axis, eye), TRANS_TOL)
			&& near(fr(m.trans.y), -dot_uf(m.y_axis, eye), TRANS_TOL)
			&& near(fr(m.trans.z), -dot_uf(m.z_axis, eye), TRANS_TOL);
	endfunction

	function automatic bit vertex_ok(input vec3_t o, input vec3_t v, input view_mat_t m);
		return near(fr(o.x), dot_uf(m.x_axis, v) + fr(m.trans.x), VERTEX_TOL)
			&& near(fr(o.y), dot_uf(m.y_axis, v) + fr(m.trans.y), VERTEX_TOL)
			&& near(fr(o.z), dot_uf(m.z_axis, v) + fr(m.trans.z), VERTEX_TOL);
	endfunction

	always_ff @(posedge clk) begin
		if (!srst_n)
			seen_ready <= 1'b0;
		else if (view_ready)
			seen_ready <= 1'b1;
	end

	// ************************************************************
	// assertions
	// ************************************************************

	quiet_before_view: assert property (@(posedge clk) disable iff (!srst_n)
		(!seen_ready && !view_ready) |-> (!view_valid && !out_valid))
	else begin
		fail_count++;
		$error("** Error view_valid = %h out_valid = %h before first view_ready",
			view_valid, out_valid);
	end

	axes_orthonormal: assert property (@(posedge clk) disable iff (!srst_n)
		view_ready |-> orthonormal(view))
	else begin
		fail_count++;
		$error("** Error view.x_axis = %h view.y_axis = %h view.z_axis = %h",
			view.x_axis, view.y_axis, view.z_axis);
	end

	axes_follow_camera: assert property (@(posedge clk) disable iff (!srst_n)
		view_ready |-> follows_camera(view, camera))
	else begin
		fail_count++;
		$error("** Error view.z_axis = %h view.x_axis = %h camera = %h",
			view.z_axis, view.x_axis, camera);
	end

	trans_matches_eye: assert property (@(posedge clk) disable iff (!srst_n)
		view_ready |-> trans_ok(view, camera.eye))
	else begin
		fail_count++;
		$error("** Error view.trans = %h camera.eye = %h", view.trans, camera.eye);
	end

	out_valid_timing: assert property (@(posedge clk) disable iff (!srst_n)
		out_valid == ($past(vertex_valid, 2) && $past(view_valid, 2)))
	else begin
		fail_count++;
		$error("** Error out_valid = %h two cycles after a vertex strobe", out_valid);
	end

	vertex_in_view_space: assert property (@(posedge clk) disable iff (!srst_n)
		out_valid |-> vertex_ok(vertex_out, $past(vertex_in, 2), $past(view, 2)))
	else begin
		fail_count++;
		$error("** Error vertex_out = %h view.trans = %h", vertex_out, view.trans);
	end

endmodule

`default_nettype wire

//--- verilog/camera_basis.sv
`default_nettype none

module camera_basis import vertex_shader_pkg::*; #(
	parameter int INV_SQRT_STAGES = vertex_shader_pkg::INV_SQRT_STAGES
) (
	input wire clk,
	input wire srst_n,
	input wire enable,
	input wire camera_t camera,
	output view_mat_t view,
	output logic view_ready,
	output logic view_valid
);

	typedef enum logic [2:0] {
		IDLE,
		GET_CAMZ,
		GET_CAMX,
		GET_CAMY,
		DONE
	} state_t;

	// step numbers inside each phase
	localparam logic [5:0] Z_SCALE = 6'(INV_SQRT_STAGES + 1);
	localparam logic [5:0] CROSS_READ = 6'd2;
	localparam logic [5:0] DOT_READ = 6'd5;
	localparam logic [5:0] AXIS_SCALE = 6'(INV_SQRT_STAGES + 3);
	localparam logic [5:0] Y_DOT = 6'(INV_SQRT_STAGES + 4);
	localparam logic [5:0] Y_LAST = 6'(INV_SQRT_STAGES + 6);

	state_t state;
	logic [5:0] cnt;
	camera_t cam_q;
	vec3_t z_raw;
	vec3_t x_raw;
	vec3_t y_raw;

	// unit operands and results
	vec3_t isq_v;
	unit_t inv_len;
	vec3_t cp_u;
	vec3_t cp_v;
	vec3_t cp_out;
	uvec3_t nd_a;
	fix_t nd_out;

	// 4Q20 component times 2Q24 reciprocal, rounded to 2Q24
	function automatic unit_t scale(input fix_t c, input unit_t r);
		logic signed [FIX_W+UNIT_W-1:0] p;
		p = c * r + (1 <<< (FIX_FRAC - 1));
		return unit_t'(p >>> FIX_FRAC);
	endfunction

	function automatic uvec3_t scale_vec(input vec3_t c, input unit_t r);
		uvec3_t s;
		s.x = scale(c.x, r);
		s.y = scale(c.y, r);
		s.z = scale(c.z, r);
		return s;
	endfunction

	// 2Q24 down to 4Q20 with rounding
	function automatic fix_t unit_to_fix(input unit_t u);
		unit_t r;
		r = u + unit_t'(1 << (UNIT_FRAC - FIX_FRAC - 1));
		return fix_t'(r >>> (UNIT_FRAC - FIX_FRAC));
	endfunction

	function automatic vec3_t unit_to_fix_vec(input uvec3_t u);
		vec3_t f;
		f.x = unit_to_fix(u.x);
		f.y = unit_to_fix(u.y);
		f.z = unit_to_fix(u.z);
		return f;
	endfunction

	inv_sqrt #(.STAGES(INV_SQRT_STAGES)) inv_sqrt0 (
		.clk(clk),
		.v(isq_v),
		.inv_len(inv_len)
	);

	cross_product cross_product0 (
		.clk(clk),
		.u(cp_u),
		.v(cp_v),
		.out(cp_out)
	);

	neg_dot_product neg_dot_product0 (
		.clk(clk),
		.a(nd_a),
		.b(cam_q.eye),
		.out(nd_out)
	);

	// ************************************************************
	// camera basis sequence
	//   Z = norm(eye - center)
	//   X = norm(up x Z), with -Z.eye in the shadow of 1/|X|
	//   Y = norm(Z x X), with -X.eye in the shadow of 1/|Y|
	// operands are held for a whole phase, results taken by step
	// ************************************************************

	always_comb begin
		cp_u = unit_to_fix_vec(view.z_axis);
		cp_v = unit_to_fix_vec(view.x_axis);
		nd_a = view.z_axis;
		isq_v = z_raw;
		case (state)
			GET_CAMX: begin
				cp_u = cam_q.up;
				cp_v = unit_to_fix_vec(view.z_axis);
				isq_v = x_raw;
			end
			GET_CAMY: begin
				isq_v = y_raw;
				// switch to Y once it is normalized
				nd_a = (cnt < Y_DOT) ? view.x_axis : view.y_axis;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!srst_n) begin
			state <= IDLE;
			cnt <= '0;
			view_valid <= 1'b0;
		end else begin
			cnt <= cnt + 6'd1;
			case (state)
				IDLE: begin
					cnt <= '0;
					if (enable) begin
						state <= GET_CAMZ;
						view_valid <= 1'b0;
					end
				end
				GET_CAMZ: begin
					if (cnt == Z_SCALE) begin
						state <= GET_CAMX;
						cnt <= '0;
					end
				end
				GET_CAMX: begin
					if (cnt == AXIS_SCALE) begin
						state <= GET_CAMY;
						cnt <= '0;
					end
				end
				GET_CAMY: begin
					if (cnt == Y_LAST) begin
						state <= DONE;
						view_valid <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && enable)
			cam_q <= camera;
		case (state)
			GET_CAMZ: begin
				if (cnt == 6'd0) begin
					z_raw.x <= cam_q.eye.x - cam_q.center.x;
					z_raw.y <= cam_q.eye.y - cam_q.center.y;
					z_raw.z <= cam_q.eye.z - cam_q.center.z;
				end
				if (cnt == Z_SCALE)
					view.z_axis <= scale_vec(z_raw, inv_len);
			end
			GET_CAMX: begin
				if (cnt == CROSS_READ)
					x_raw <= cp_out;
				if (cnt == DOT_READ)
					view.trans.z <= nd_out;
				if (cnt == AXIS_SCALE)
					view.x_axis <= scale_vec(x_raw, inv_len);
			end
			GET_CAMY: begin
				if (cnt == CROSS_READ)
					y_raw <= cp_out;
				if (cnt == DOT_READ)
					view.trans.x <= nd_out;
				if (cnt == AXIS_SCALE)
					view.y_axis <= scale_vec(y_raw, inv_len);
				if (cnt == Y_LAST)
					view.trans.y <= nd_out;
			end
			default: ;
		endcase
	end

	// the one cycle in DONE is the update pulse
	assign view_ready = (state == DONE);

endmodule

`default_nettype wire

//--- verilog/cross_product.sv
`default_nettype none

module cross_product import vertex_shader_pkg::*; (
	input wire clk,
	input wire vec3_t u,
	input wire vec3_t v,
	output vec3_t out
);

	// Q40 partial products
	logic signed [2*FIX_W-1:0] prod_q [6];

	// difference of two Q40 products, rounded to 4Q20
	function automatic fix_t round_diff(input logic signed [2*FIX_W-1:0] a,
			input logic signed [2*FIX_W-1:0] b);
		logic signed [2*FIX_W:0] d;
		d = (2*FIX_W+1)'(a) - (2*FIX_W+1)'(b) + (1 <<< (FIX_FRAC - 1));
		return fix_t'(d >>> FIX_FRAC);
	endfunction

	always_ff @(posedge clk) begin
		prod_q[0] <= u.y * v.z;
		prod_q[1] <= u.z * v.y;
		prod_q[2] <= u.z * v.x;
		prod_q[3] <= u.x * v.z;
		prod_q[4] <= u.x * v.y;
		prod_q[5] <= u.y * v.x;
	end

	always_ff @(posedge clk) begin
		out.x <= round_diff(prod_q[0], prod_q[1]);
		out.y <= round_diff(prod_q[2], prod_q[3]);
		out.z <= round_diff(prod_q[4], prod_q[5]);
	end

endmodule

`default_nettype wire

//--- verilog/inv_sqrt.sv
`default_nettype none

module inv_sqrt import vertex_shader_pkg::*; #(
	parameter int STAGES = INV_SQRT_STAGES
) (
	input wire clk,
	input wire vec3_t v,
	output unit_t inv_len
);

	// sum stage, seed stage and output stage take three of the stages
	localparam int ITERS = STAGES - 3;
	localparam logic [51:0] UNIT_MAX = (52'd1 << (UNIT_W - 1)) - 52'd1;

	logic signed [2*FIX_W-1:0] sq_x;
	logic signed [2*FIX_W-1:0] sq_y;
	logic signed [2*FIX_W-1:0] sq_z;
	logic [47:0] sum_d;
	logic [47:0] sum_q;
	logic [47:0] sum_nz;
	logic [5:0] sh_d;
	logic [47:0] norm_d;
	logic [51:0] scaled_d;

	// mantissa in [1,4) and estimate of 1/sqrt in Q24
	logic [25:0] m_q [ITERS];
	logic [25:0] y_q [ITERS+1];
	logic [5:0] sh_q [ITERS+1];

	// even left shift that brings the leading one into bit 47 or 46
	function automatic logic [5:0] even_shift(input logic [47:0] s);
		logic [5:0] p;
		p = 6'd0;
		for (int i = 0; i < 48; i++) begin
			if (s[i])
				p = 6'(i);
		end
		return (6'd47 - p) & 6'b111110;
	endfunction

	// Q8 values of 1/sqrt at the middle of each quarter step of m
	function automatic logic [7:0] seed_lut(input logic [3:0] idx);
		case (idx)
			4'd4: return 8'd241;
			4'd5: return 8'd218;
			4'd6: return 8'd201;
			4'd7: return 8'd187;
			4'd8: return 8'd176;
			4'd9: return 8'd166;
			4'd10: return 8'd158;
			4'd11: return 8'd151;
			4'd12: return 8'd145;
			4'd13: return 8'd139;
			4'd14: return 8'd134;
			4'd15: return 8'd130;
			// m below 1 never reaches here
			default: return 8'd255;
		endcase
	endfunction

	// y * (3 - m*y*y) / 2
	function automatic logic [25:0] newton(input logic [25:0] m, input logic [25:0] y);
		logic [51:0] y2;
		logic [51:0] my2;
		logic [26:0] t;
		logic [52:0] yt;
		y2 = y * y;
		my2 = m * y2[49:24];
		t = (27'd3 << 24) - my2[50:24];
		yt = y * t;
		return yt[50:25];
	endfunction

	always_comb begin
		sq_x = v.x * v.x;
		sq_y = v.y * v.y;
		sq_z = v.z * v.z;
		sum_d = sq_x + sq_y + sq_z;
	end

	// a zero length is pushed to the smallest value and saturates below
	always_comb begin
		sum_nz = (sum_q == '0) ? 48'd1 : sum_q;
		sh_d = even_shift(sum_nz);
		norm_d = sum_nz << sh_d;
	end

	// undo half the shift and the exponent offset of 3 from the Q40 input
	always_comb begin
		scaled_d = (({26'd0, y_q[ITERS]} << sh_q[ITERS][5:1]) + 52'd4) >> 3;
	end

	always_ff @(posedge clk) begin
		sum_q <= sum_d;
		m_q[0] <= norm_d[47:22];
		y_q[0] <= {2'b00, seed_lut(norm_d[47:44]), 16'd0};
		sh_q[0] <= sh_d;
		for (int k = 1; k < ITERS; k++) begin
			m_q[k] <= m_q[k-1];
		end
		for (int k = 1; k <= ITERS; k++) begin
			sh_q[k] <= sh_q[k-1];
			y_q[k] <= newton(m_q[k-1], y_q[k-1]);
		end
		if (scaled_d > UNIT_MAX)
			inv_len <= unit_t'(UNIT_MAX);
		else
			inv_len <= unit_t'(scaled_d[UNIT_W-1:0]);
	end

endmodule

`default_nettype wire

//--- verilog/neg_dot_product.sv
`default_nettype none

module neg_dot_product import vertex_shader_pkg::*; (
	input wire clk,
	input wire uvec3_t a,
	input wire vec3_t b,
	output fix_t out
);

	prod_t prod_q [3];
	acc_t sum_d;

	always_ff @(posedge clk) begin
		prod_q[0] <= mul_round(a.x, b.x);
		prod_q[1] <= mul_round(a.y, b.y);
		prod_q[2] <= mul_round(a.z, b.z);
	end

	always_comb begin
		sum_d = prod_q[0] + prod_q[1] + prod_q[2];
	end

	// result lands in 4Q20, eye stays inside the 4Q20 range
	always_ff @(posedge clk) begin
		out <= fix_t'(-sum_d);
	end

endmodule

`default_nettype wire

//--- verilog/vertex_shader.sv
`default_nettype none

module vertex_shader import vertex_shader_pkg::*; #(
	parameter int INV_SQRT_STAGES = vertex_shader_pkg::INV_SQRT_STAGES
) (
	input wire clk,
	input wire srst_n,
	input wire enable,
	input wire camera_t camera,
	input wire vertex_valid,
	input wire vec3_t vertex_in,
	output wire view_mat_t view,
	output wire view_ready,
	output wire view_valid,
	output wire out_valid,
	output wire vec3_t vertex_out
);

	// view matrix setup, once per enable
	camera_basis #(
		.INV_SQRT_STAGES(INV_SQRT_STAGES)
	) camera_basis0 (
		.clk(clk),
		.srst_n(srst_n),
		.enable(enable),
		.camera(camera),
		.view(view),
		.view_ready(view_ready),
		.view_valid(view_valid)
	);

	// per vertex, two cycles
	vertex_transform vertex_transform0 (
		.clk(clk),
		.srst_n(srst_n),
		.view(view),
		.view_valid(view_valid),
		.vertex_valid(vertex_valid),
		.vertex_in(vertex_in),
		.out_valid(out_valid),
		.vertex_out(vertex_out)
	);

endmodule

`default_nettype wire

//--- verilog/vertex_shader_pkg.sv
`default_nettype none

package vertex_shader_pkg;

	// 4Q20 positions and vertices
	localparam int FIX_W = 24;
	localparam int FIX_FRAC = 20;

	// 2Q24 unit axis components
	localparam int UNIT_W = 26;
	localparam int UNIT_FRAC = 24;

	// default latency of the reciprocal square root
	localparam int INV_SQRT_STAGES = 8;

	typedef logic signed [FIX_W-1:0] fix_t;
	typedef logic signed [UNIT_W-1:0] unit_t;

	// rounded unit times fixed product, 6Q20
	typedef logic signed [FIX_W+1:0] prod_t;

	// sum of up to four products, 8Q20
	typedef logic signed [FIX_W+3:0] acc_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec3_t;

	typedef struct packed {
		unit_t x;
		unit_t y;
		unit_t z;
	} uvec3_t;

	typedef struct packed {
		vec3_t eye;
		vec3_t center;
		vec3_t up;
	} camera_t;

	// view matrix rows, bottom row 0 0 0 1 is implicit
	typedef struct packed {
		uvec3_t x_axis;
		uvec3_t y_axis;
		uvec3_t z_axis;
		vec3_t trans;
	} view_mat_t;

	// 2Q24 x 4Q20 gives Q44, rounded back to Q20
	function automatic prod_t mul_round(input unit_t a, input fix_t b);
		logic signed [UNIT_W+FIX_W-1:0] p;
		p = a * b + (1 <<< (UNIT_FRAC - 1));
		return prod_t'(p >>> UNIT_FRAC);
	endfunction

endpackage

`default_nettype wire

//--- verilog/vertex_transform.sv
`default_nettype none

module vertex_transform import vertex_shader_pkg::*; (
	input wire clk,
	input wire srst_n,
	input wire view_mat_t view,
	input wire view_valid,
	input wire vertex_valid,
	input wire vec3_t vertex_in,
	output logic out_valid,
	output vec3_t vertex_out
);

	uvec3_t rows [3];
	fix_t offs [3];
	prod_t prod_q [3][3];
	acc_t acc_d [3];
	logic valid_q;

	assign rows[0] = view.x_axis;
	assign rows[1] = view.y_axis;
	assign rows[2] = view.z_axis;
	assign offs[0] = view.trans.x;
	assign offs[1] = view.trans.y;
	assign offs[2] = view.trans.z;

	// ************************************************************
	// stage 1, axis times coordinate
	// ************************************************************

	always_ff @(posedge clk) begin
		for (int r = 0; r < 3; r++) begin
			prod_q[r][0] <= mul_round(rows[r].x, vertex_in.x);
			prod_q[r][1] <= mul_round(rows[r].y, vertex_in.y);
			prod_q[r][2] <= mul_round(rows[r].z, vertex_in.z);
		end
	end

	// ************************************************************
	// stage 2, row sums plus translation
	// ************************************************************

	always_comb begin
		for (int r = 0; r < 3; r++) begin
			acc_d[r] = prod_q[r][0] + prod_q[r][1] + prod_q[r][2] + offs[r];
		end
	end

	always_ff @(posedge clk) begin
		vertex_out.x <= fix_t'(acc_d[0]);
		vertex_out.y <= fix_t'(acc_d[1]);
		vertex_out.z <= fix_t'(acc_d[2]);
	end

	// vertices without a valid view are dropped here
	always_ff @(posedge clk) begin
		if (!srst_n) begin
			valid_q <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			valid_q <= vertex_valid & view_valid;
			out_valid <= valid_q;
		end
	end

endmodule

`default_nettype wire
